// ==== hw/aux_pkg.sv ====
// ****************************************
// AUX package: I2C-over-AUX command and reply
// codes, request/reply structs, timing limits
// ****************************************
package aux_pkg;

    // Sink reply code, 2'd3 is reserved
    typedef enum logic [1:0]
    {
        ACK   = 2'd0,
        NACK  = 2'd1,
        DEFER = 2'd2
    } reply_code_e;

    // One reply from the sink
    typedef struct packed
    {
        reply_code_e code;                                  // ACK / NACK / DEFER
        logic [7:0]  data;                                  // Read byte, valid on ACK to DATA
    } aux_reply_t;

    // One AUX request header
    typedef struct packed
    {
        logic [3:0] cmd;                                    // AUX command code
        logic [6:0] addr;                                   // I2C slave address
        logic [7:0] len;                                    // 0 address only, 1 one-byte read
    } aux_req_t;

    // I2C read, bit 2 is MOT
    localparam logic [3:0] CMD_I2C_READ_MOT = 4'b0101;      // Keep the I2C transaction open
    localparam logic [3:0] CMD_I2C_READ     = 4'b0001;      // Closes with a stop

    localparam logic [6:0] EDID_I2C_ADDR    = 7'h50;        // DDC EDID slave

    // 400 us reply limit scaled down for the model
    localparam logic [7:0] REPLY_TIMEOUT    = 8'd32;

    localparam int         CMD_FIFO_DEPTH   = 4;            // Rarely more than one entry
    localparam int         BYTE_FIFO_DEPTH  = 8;            // Host side slack

endpackage

// ==== hw/aux_req_builder.sv ====
// ****************************************
// AUX request builder: commands to request
// headers, reply capture, timer, byte push
// ****************************************
`timescale 1ns/10ps

module aux_req_builder
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  edid_pkg::edid_cmd_t  cmd,                       // Head of the command FIFO
    input  logic                 cmd_avail,
    input  logic                 byte_full,                 // Byte FIFO back-pressure
    input  aux_pkg::aux_reply_t  reply,                     // From the sink
    input  logic                 reply_vld,
    output logic                 cmd_pop,
    output aux_pkg::aux_req_t    req,                       // To the sink
    output logic                 req_vld,
    output aux_pkg::aux_reply_t  rsp,                       // Registered copy to the FSM
    output logic                 rsp_vld,
    output logic                 timeout,
    output logic                 byte_push,
    output logic [7:0]           byte_data
);

    logic                 outstanding;                      // Request sent, no answer yet
    logic [7:0]           timer;                            // Cycles since req_vld
    edid_pkg::edid_kind_e out_kind;                         // Kind of the open request
    aux_pkg::aux_req_t    hdr;
    logic                 reply_known;
    logic                 reply_take;
    logic                 timer_expired;

    // One request at a time, and room for its byte
    assign cmd_pop = cmd_avail && !outstanding && !byte_full;

    assign reply_known   = reply.code inside {aux_pkg::ACK, aux_pkg::NACK, aux_pkg::DEFER};
    assign reply_take    = reply_vld && reply_known && outstanding;   // Stray replies dropped
    assign timer_expired = outstanding && !reply_take &&
                           (timer == aux_pkg::REPLY_TIMEOUT - 8'd1);

    // Header for the command at the FIFO head
    always_comb
    begin
        hdr.addr = aux_pkg::EDID_I2C_ADDR;
        case (cmd.kind)
            edid_pkg::ADDR:
            begin
                hdr.cmd = aux_pkg::CMD_I2C_READ_MOT;
                hdr.len = 8'd0;                             // Address only
            end
            edid_pkg::DATA:
            begin
                hdr.cmd = aux_pkg::CMD_I2C_READ_MOT;
                hdr.len = 8'd1;                             // One byte
            end
            edid_pkg::STOP:
            begin
                hdr.cmd = aux_pkg::CMD_I2C_READ;            // MOT clear ends the read
                hdr.len = 8'd0;
            end
            default:
            begin
                hdr.cmd = aux_pkg::CMD_I2C_READ;
                hdr.len = 8'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            outstanding <= 1'b0;
            timer       <= '0;
            req_vld     <= 1'b0;
            rsp_vld     <= 1'b0;
            timeout     <= 1'b0;
            byte_push   <= 1'b0;
        end
        else
        begin
            req_vld <= cmd_pop;                             // Header out the cycle after pop
            if (cmd_pop)
            begin
                outstanding <= 1'b1;
                timer       <= '0;
            end
            else if (reply_take || timer_expired)
            begin
                outstanding <= 1'b0;
            end
            else if (outstanding)
            begin
                timer <= timer + 8'd1;
            end
            rsp_vld   <= reply_take;
            timeout   <= timer_expired;                     // Pulse, FSM re-pushes
            byte_push <= reply_take && (reply.code == aux_pkg::ACK) &&
                         (out_kind == edid_pkg::DATA);
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_pop)
        begin
            req      <= hdr;
            out_kind <= cmd.kind;
        end
        if (reply_take)
        begin
            rsp       <= reply;
            byte_data <= reply.data;
        end
    end

endmodule

// ==== hw/edid_pkg.sv ====
// ****************************************
// EDID package: transaction phases, command
// struct and block read limits
// ****************************************
package edid_pkg;

    // Phase a queued command belongs to
    typedef enum logic [1:0]
    {
        ADDR = 2'd0,                                        // Address only, MOT set
        DATA = 2'd1,                                        // One-byte read, MOT set
        STOP = 2'd2                                         // Address only, MOT clear
    } edid_kind_e;

    typedef struct packed
    {
        edid_kind_e kind;
    } edid_cmd_t;

    localparam logic [7:0] EDID_SIZE   = 8'd128;            // Base block only
    localparam logic [3:0] DEFER_LIMIT = 4'd8;              // DEFERs per transaction

endpackage

// ==== hw/edid_reader_top.sv ====
// ****************************************
// EDID reader top: FSM, command FIFO, AUX
// request builder and host byte FIFO
// ****************************************
`timescale 1ns/10ps

module edid_reader_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output aux_pkg::aux_req_t   req,
    output logic                req_vld,
    input  aux_pkg::aux_reply_t reply,
    input  logic                reply_vld,
    output logic [7:0]          edid_byte,
    output logic                edid_vld,
    input  logic                edid_pop,
    output logic                done,
    output logic                failed
);

    edid_pkg::edid_cmd_t fsm_cmd;                           // FSM side of the queue
    edid_pkg::edid_cmd_t head_cmd;                          // Builder side of the queue
    logic                cmd_push;
    logic                cmd_pop;
    logic                cmd_avail;
    aux_pkg::aux_reply_t rsp;
    logic                rsp_vld;
    logic                timeout;
    logic                byte_push;
    logic [7:0]          byte_data;
    logic                byte_full;

    i2c_fsm u_i2c_fsm
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .rsp      (rsp),
        .rsp_vld  (rsp_vld),
        .timeout  (timeout),
        .cmd      (fsm_cmd),
        .cmd_push (cmd_push),
        .done     (done),
        .failed   (failed)
    );

    sync_fifo #(.payload_t(edid_pkg::edid_cmd_t), .DEPTH(aux_pkg::CMD_FIFO_DEPTH)) u_cmd_fifo
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cmd_push),
        .din       (fsm_cmd),
        .pop       (cmd_pop),
        .dout      (head_cmd),
        .not_empty (cmd_avail),
        .full      ()                                       // FSM waits on replies, never fills it
    );

    aux_req_builder u_aux_req_builder
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (head_cmd),
        .cmd_avail (cmd_avail),
        .byte_full (byte_full),
        .reply     (reply),
        .reply_vld (reply_vld),
        .cmd_pop   (cmd_pop),
        .req       (req),
        .req_vld   (req_vld),
        .rsp       (rsp),
        .rsp_vld   (rsp_vld),
        .timeout   (timeout),
        .byte_push (byte_push),
        .byte_data (byte_data)
    );

    sync_fifo #(.payload_t(logic [7:0]), .DEPTH(aux_pkg::BYTE_FIFO_DEPTH)) u_byte_fifo
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (byte_push),
        .din       (byte_data),
        .pop       (edid_pop),
        .dout      (edid_byte),
        .not_empty (edid_vld),                              // Host sees a byte waiting
        .full      (byte_full)
    );

endmodule

// ==== hw/i2c_fsm.sv ====
// ****************************************
// I2C transaction FSM: address, data and stop
// phases of an EDID read, retry and DEFER abort
// ****************************************
`timescale 1ns/10ps

module i2c_fsm
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,                      // Begin one block read
    input  aux_pkg::aux_reply_t rsp,                        // Registered sink reply
    input  logic                rsp_vld,
    input  logic                timeout,                    // No reply in time
    output edid_pkg::edid_cmd_t cmd,                        // Command to the queue
    output logic                cmd_push,
    output logic                done,                       // Block read finished
    output logic                failed                      // Aborted on DEFER limit
);

    typedef enum logic [1:0]
    {
        IDLE    = 2'b00,
        ADDRESS = 2'b01,
        DATA    = 2'b11,
        END     = 2'b10
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic [7:0]           byte_cnt;                         // Bytes ACKed so far
    logic [7:0]           byte_cnt_nxt;
    logic [3:0]           defer_cnt;                        // DEFERs in this transaction
    logic [3:0]           defer_cnt_nxt;
    edid_pkg::edid_kind_e kind_nxt;
    logic                 push_nxt;
    logic                 done_nxt;
    logic                 failed_nxt;
    logic                 is_ack;
    logic                 is_nack;
    logic                 is_defer;
    logic                 retry;

    assign is_ack   = rsp_vld && (rsp.code == aux_pkg::ACK);
    assign is_nack  = rsp_vld && (rsp.code == aux_pkg::NACK);
    assign is_defer = rsp_vld && (rsp.code == aux_pkg::DEFER);
    assign retry    = timeout || is_nack;               // Same kind goes out again

    always_comb
    begin
        state_nxt     = state;
        byte_cnt_nxt  = byte_cnt;
        defer_cnt_nxt = defer_cnt;
        kind_nxt      = cmd.kind;                       // Re-push keeps the last kind
        push_nxt      = 1'b0;
        done_nxt      = 1'b0;
        failed_nxt    = 1'b0;

        case (state)
            IDLE:
            begin
                byte_cnt_nxt  = '0;
                defer_cnt_nxt = '0;                     // Only place it clears
                if (start)
                begin
                    state_nxt = ADDRESS;
                    push_nxt  = 1'b1;
                    kind_nxt  = edid_pkg::ADDR;
                end
            end
            ADDRESS:
            begin
                if (is_ack)
                begin
                    state_nxt = DATA;
                    push_nxt  = 1'b1;
                    kind_nxt  = edid_pkg::DATA;
                end
            end
            DATA:
            begin
                if (is_ack)
                begin
                    byte_cnt_nxt = byte_cnt + 8'd1;
                    push_nxt     = 1'b1;
                    if (byte_cnt == edid_pkg::EDID_SIZE - 8'd1)
                    begin
                        state_nxt = END;                // Last byte in, close the read
                        kind_nxt  = edid_pkg::STOP;
                    end
                    else
                    begin
                        kind_nxt = edid_pkg::DATA;
                    end
                end
            end
            END:
            begin
                if (is_ack)
                begin
                    state_nxt = IDLE;
                    done_nxt  = 1'b1;
                end
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase

        // NACK, timeout and DEFER act alike in every busy phase
        if (state != IDLE)
        begin
            if (retry)
            begin
                push_nxt = 1'b1;
            end
            else if (is_defer)
            begin
                defer_cnt_nxt = defer_cnt + 4'd1;
                if (defer_cnt_nxt == edid_pkg::DEFER_LIMIT)
                begin
                    state_nxt  = IDLE;                  // Give up on this sink
                    failed_nxt = 1'b1;
                end
                else
                begin
                    push_nxt = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            byte_cnt  <= '0;
            defer_cnt <= '0;
            cmd_push  <= 1'b0;
            done      <= 1'b0;
            failed    <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            byte_cnt  <= byte_cnt_nxt;
            defer_cnt <= defer_cnt_nxt;
            cmd_push  <= push_nxt;                      // Registered, one cycle after cause
            done      <= done_nxt;
            failed    <= failed_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_nxt)
        begin
            cmd.kind <= kind_nxt;
        end
    end

endmodule

// ==== hw/sync_fifo.sv ====
// ****************************************
// Single-clock FIFO, payload set by a
// type parameter, head shown on dout
// ****************************************
`timescale 1ns/10ps

module sync_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,                                  // Head entry
    output logic     not_empty,
    output logic     full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;                                 // Occupancy, 0 to DEPTH
    logic            do_push;
    logic            do_pop;

    assign do_push   = push && !full;                       // Push on full is dropped
    assign do_pop    = pop && not_empty;
    assign full      = (count == (AW+1)'(DEPTH));
    assign not_empty = (count != '0);
    assign dout      = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                    // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== project.f ====
hw/aux_pkg.sv
hw/edid_pkg.sv
hw/sync_fifo.sv
hw/i2c_fsm.sv
hw/aux_req_builder.sv
hw/edid_reader_top.sv
tests/edid_reader_assertions.sv
tests/tb_edid_reader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the EDID reader testbench with Verilator, run it and scan the log

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    -f project.f --top-module tb_edid_reader -Mdir "$BUILD_DIR" -o tb_edid_reader
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/tb_edid_reader" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Run finished without a reported failure"
exit 0

// ==== tests/edid_reader_assertions.sv ====
// ****************************************
// EDID reader checker: result pulses, single
// outstanding request, FIFO overflow
// ****************************************
`timescale 1ns/10ps

module edid_reader_assertions
(
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic failed,
    input logic req_vld,
    input logic rsp_vld,                                    // Builder forwarded a reply
    input logic timeout,                                    // Builder stopped waiting
    input logic cmd_push,
    input logic cmd_full,
    input logic byte_push,
    input logic byte_full
);

    logic req_open;                                         // Header sent, not yet closed

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_open <= 1'b0;
        end
        else if (req_vld)
        begin
            req_open <= 1'b1;
        end
        else if (rsp_vld || timeout)
        begin
            req_open <= 1'b0;                               // Answered or timed out
        end
    end

    result_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && failed))
        else $error("done and failed high in the same cycle");

    single_request: assert property (@(posedge clk) disable iff (!rst_n)
        req_vld |-> !req_open)
        else $error("request issued while another one was outstanding");

    cmd_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_push |-> !cmd_full)
        else $error("push into a full command FIFO");

    byte_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        byte_push |-> !byte_full)
        else $error("push into a full byte FIFO");

endmodule

bind edid_reader_top edid_reader_assertions u_checker
(
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (done),
    .failed    (failed),
    .req_vld   (req_vld),
    .rsp_vld   (rsp_vld),
    .timeout   (timeout),
    .cmd_push  (cmd_push),
    .cmd_full  (u_cmd_fifo.full),
    .byte_push (byte_push),
    .byte_full (byte_full)
);

// ==== tests/tb_edid_reader.sv ====
// ****************************************
// EDID reader testbench: AUX sink model,
// host byte reader, header and result checks
// ****************************************
`timescale 1ns/10ps

module tb_edid_reader;

    localparam int RUNS       = 6;
    localparam int MAX_CYCLES = RUNS * (int'(edid_pkg::EDID_SIZE) + 2) *
                                (int'(aux_pkg::REPLY_TIMEOUT) + 10) * 8;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    aux_pkg::aux_req_t    req;
    logic                 req_vld;
    aux_pkg::aux_reply_t  reply;
    logic                 reply_vld;
    logic [7:0]           edid_byte;
    logic                 edid_vld;
    logic                 edid_pop;
    logic                 done;
    logic                 failed;

    logic [7:0]           lfsr;                             // Fibonacci state
    int                   cycle_cnt;
    edid_pkg::edid_kind_e exp_kind;                         // Kind the next header must carry
    int                   sink_idx;                         // Bytes ACKed by the sink
    int                   host_idx;                         // Bytes popped by the host
    int                   defer_cnt;
    int                   req_cnt;
    int                   reply_wait;                       // Negedges left until the reply
    aux_pkg::aux_reply_t  pend_reply;
    int                   nack_w;                           // Weights out of 16
    int                   defer_w;
    int                   silent_w;
    logic                 abort_mode;                       // DEFER all from byte 5 on
    logic                 stall_mode;                       // Host pauses after each pop
    int                   stall_cnt;
    logic                 run_active;
    logic                 result_seen;
    logic [1:0]           exp_result;                       // {done, failed}
    logic [1:0]           got_result;

    edid_reader_top u_dut
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .req       (req),
        .req_vld   (req_vld),
        .reply     (reply),
        .reply_vld (reply_vld),
        .edid_byte (edid_byte),
        .edid_vld  (edid_vld),
        .edid_pop  (edid_pop),
        .done      (done),
        .failed    (failed)
    );

    always #10 clk = ~clk;                                  // 20 ns period

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val  = (val << 1) | int'(lfsr[7]);              // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Byte the sink holds at each block offset
    function automatic logic [7:0] ref_edid_byte(input int idx);
        logic [7:0] b;
        if (idx == 0 || idx == 7)
            b = 8'h00;
        else if (idx < 8)
            b = 8'hFF;                                      // Fixed EDID header
        else
            b = 8'(idx * 29 + 60) ^ 8'(idx >> 4);
        return b;
    endfunction

    function automatic aux_pkg::aux_req_t header_for(input edid_pkg::edid_kind_e kind);
        aux_pkg::aux_req_t h;
        h.addr = aux_pkg::EDID_I2C_ADDR;
        h.cmd  = (kind == edid_pkg::STOP) ? aux_pkg::CMD_I2C_READ : aux_pkg::CMD_I2C_READ_MOT;
        h.len  = (kind == edid_pkg::DATA) ? 8'd1 : 8'd0;
        return h;
    endfunction

    task automatic abort_sim();
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_req(input aux_pkg::aux_req_t got, input aux_pkg::aux_req_t exp);
        if (got !== exp)
        begin
            $display("Fail req: got %h expected %h at request %0d", got, exp, req_cnt);
            abort_sim();
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("Fail edid_byte: got %h expected %h at offset %0d", got, exp, host_idx);
            abort_sim();
        end
    endtask

    task automatic check_done(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
        begin
            $display("Fail {done,failed}: got %h expected %h", got, exp);
            abort_sim();
        end
    endtask

    // Pick the answer to one request and advance the phase model
    task automatic choose_reply();
        int   r;
        int   d;
        logic silent;
        aux_pkg::reply_code_e code;
        take_bits(2, d);
        take_bits(4, r);
        silent = 1'b0;
        code   = aux_pkg::ACK;
        if (abort_mode && exp_kind == edid_pkg::DATA && sink_idx >= 5)
            code = aux_pkg::DEFER;
        else if (r < nack_w)
            code = aux_pkg::NACK;
        else if (r < nack_w + defer_w)
        begin
            if (defer_cnt < int'(edid_pkg::DEFER_LIMIT) - 1)
                code = aux_pkg::DEFER;                      // Stay below the abort
        end
        else if (r < nack_w + defer_w + silent_w)
            silent = 1'b1;
        if (silent)
            reply_wait = 0;                                 // DUT times out and reissues
        else
        begin
            pend_reply.code = code;
            pend_reply.data = 8'hEE;                        // Junk unless a byte is due
            reply_wait      = 2 + d;                        // 2 to 5 cycles
            if (code == aux_pkg::ACK)
            begin
                if (exp_kind == edid_pkg::ADDR)
                    exp_kind = edid_pkg::DATA;
                else if (exp_kind == edid_pkg::DATA)
                begin
                    pend_reply.data = ref_edid_byte(sink_idx);
                    sink_idx++;
                    if (sink_idx == int'(edid_pkg::EDID_SIZE))
                        exp_kind = edid_pkg::STOP;
                end
                else
                    exp_result = 2'b10;                     // STOP ACKed
            end
            else if (code == aux_pkg::DEFER)
            begin
                defer_cnt++;
                if (defer_cnt == int'(edid_pkg::DEFER_LIMIT))
                    exp_result = 2'b01;
            end
        end
    endtask

    // Sink, host reader and result monitor
    always @(negedge clk)
    begin : sink_and_host
        int v;
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_sim();
        end
        reply_vld = 1'b0;
        if (reply_wait > 0)
        begin
            reply_wait--;
            if (reply_wait == 0)
            begin
                reply     = pend_reply;
                reply_vld = 1'b1;
            end
        end
        if (req_vld)
        begin
            if (reply_wait > 0)
            begin
                $display("Error: a new request came before the reply to the last one");
                abort_sim();
            end
            if (u_dut.byte_full)
            begin
                $display("Error: a request went out while the byte FIFO was full");
                abort_sim();
            end
            req_cnt++;
            check_req(req, header_for(exp_kind));
            choose_reply();
        end
        edid_pop = 1'b0;
        if (stall_cnt > 0)
            stall_cnt--;
        else if (edid_vld)
        begin
            if (host_idx >= sink_idx)
            begin
                $display("Error: the host got more bytes than the sink sent");
                abort_sim();
            end
            check_byte(edid_byte, ref_edid_byte(host_idx));
            host_idx++;
            edid_pop = 1'b1;
            if (stall_mode)
            begin
                take_bits(6, v);
                stall_cnt = v;                              // Up to 63 idle cycles
            end
        end
        if (done || failed)
        begin
            if (!run_active || result_seen)
            begin
                $display("Error: a result pulse came outside its single expected slot");
                abort_sim();
            end
            got_result  = {done, failed};
            result_seen = 1'b1;
            check_done(got_result, exp_result);
        end
    end

    task automatic run_read(input int nack, input int defer, input int silent,
                            input logic abort, input logic stall, input logic [1:0] want);
        @(posedge clk);
        nack_w      = nack;
        defer_w     = defer;
        silent_w    = silent;
        abort_mode  = abort;
        stall_mode  = stall;
        sink_idx    = 0;
        host_idx    = 0;
        defer_cnt   = 0;
        req_cnt     = 0;
        stall_cnt   = 0;
        exp_kind    = edid_pkg::ADDR;
        exp_result  = 2'b00;
        result_seen = 1'b0;
        run_active  = 1'b1;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!result_seen)
            @(posedge clk);
        while (host_idx != sink_idx)
            @(posedge clk);                                 // Host drains the FIFO
        repeat (20) @(posedge clk);                         // Window for a second pulse
        check_done(got_result, want);
        if (want == 2'b10 && host_idx != int'(edid_pkg::EDID_SIZE))
        begin
            $display("Error: only %0d bytes of the block reached the host", host_idx);
            abort_sim();
        end
        if (nack == 0 && defer == 0 && silent == 0 && !abort &&
            req_cnt != int'(edid_pkg::EDID_SIZE) + 2)
        begin
            $display("Error: a clean read used %0d requests", req_cnt);
            abort_sim();
        end
        run_active = 1'b0;
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        reply       = '0;
        reply_vld   = 1'b0;
        edid_pop    = 1'b0;
        lfsr        = 8'd82;
        cycle_cnt   = 0;
        reply_wait  = 0;
        pend_reply  = '0;
        stall_cnt   = 0;
        sink_idx    = 0;
        host_idx    = 0;
        run_active  = 1'b0;
        result_seen = 1'b0;
        exp_result  = 2'b00;
        got_result  = 2'b00;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (req_vld !== 1'b0 || done !== 1'b0 || failed !== 1'b0 || edid_vld !== 1'b0)
        begin
            $display("Fail reset: req_vld %h done %h failed %h edid_vld %h expected all 0",
                     req_vld, done, failed, edid_vld);
            abort_sim();
        end
        run_read(0, 0, 0, 1'b0, 1'b0, 2'b10);               // All ACK
        run_read(3, 1, 0, 1'b0, 1'b0, 2'b10);               // NACKs and a few DEFERs
        run_read(0, 0, 3, 1'b0, 1'b0, 2'b10);               // Silent sink at times
        run_read(0, 0, 0, 1'b1, 1'b0, 2'b01);               // Eight DEFERs abort
        run_read(0, 0, 0, 1'b0, 1'b0, 2'b10);               // Clean read after abort
        run_read(1, 0, 0, 1'b0, 1'b1, 2'b10);               // Host stalls
        $display("Simulation PASSED");
        $finish;
    end

endmodule
